// ==== filelist.f ====
verilog/pldPkg.sv
verilog/hostBus.sv
verilog/regFile.sv
verilog/wiegandTx.sv
verilog/wiegandRx.sv
verilog/pld.sv
test/tbPld.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the pld testbench, exit status is the simulator's
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module tbPld -f filelist.f \
	--Mdir obj_dir -o simPld
./obj_dir/simPld

// ==== test/tbPld.sv ====
module tbPld;
	timeunit 1ns;
	timeprecision 100ps;

	typedef logic [pldPkg::DATA_W-1:0] data_t;
	typedef logic [pldPkg::ADDR_W-1:0] addr_t;
	typedef logic [pldPkg::FRAME_BYTES*pldPkg::DATA_W-1:0] wide_t;

	// table operations
	typedef enum logic [3:0] {
		OP_WRITE, OP_READ, OP_WRFRAME, OP_RDFRAME, OP_TXEXP, OP_SEND,
		OP_WAIT_IRQ, OP_CHECK_IRQ, OP_GPIO, OP_IDLE, OP_LOCK
	} op_e;

	// idx picks a channel or a frame slot
	// data holds the expected value or a bit count
	typedef struct packed {
		op_e op;
		addr_t addr;
		data_t data;
		int idx;
	} step_t;

	logic clk = 1'b0;
	logic cfg_rst;
	logic [5:0] nGCS;
	logic nOE;
	logic nWE;
	addr_t addr;
	data_t dataIn;
	pldPkg::wiegand_t wil;
	logic lock;
	data_t dataOut;
	logic dataDrive;
	logic eint11;
	pldPkg::wiegand_t [pldPkg::NUM_TX-1:0] wilOut;
	logic [pldPkg::GPIO_W-1:0] gpioPins;

	step_t steps[$];
	pldPkg::frame_t txFrames[pldPkg::NUM_TX];
	pldPkg::frame_t rxFrames[2];
	logic [31:0] lfsrState = 32'd81309;
	int cycles = 0;
	int cycleLimit = 0;

	// pulse monitor state per tx channel
	pldPkg::frame_t monShift[pldPkg::NUM_TX];
	pldPkg::frame_t monFrame[pldPkg::NUM_TX];
	int monBits[pldPkg::NUM_TX];
	int lowCnt[pldPkg::NUM_TX];
	int highCnt[pldPkg::NUM_TX];
	int txCount[pldPkg::NUM_TX];

	pld DUT (
		.clk(clk),
		.cfg_rst(cfg_rst),
		.nGCS(nGCS),
		.nOE(nOE),
		.nWE(nWE),
		.addr(addr),
		.dataIn(dataIn),
		.wil(wil),
		.lock(lock),
		.dataOut(dataOut),
		.dataDrive(dataDrive),
		.eint11(eint11),
		.wil_out(wilOut),
		.GPIO(gpioPins)
	);

	always #4 clk = ~clk;

	task automatic abortRun(string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkData(string name, data_t exp, data_t act);
		if (act !== exp)
			abortRun($sformatf("FAILED at %0d ns: %s expected 0x%0h got 0x%0h",
				$time, name, exp, act));
	endtask

	task automatic checkFrame(string name, pldPkg::frame_t exp, pldPkg::frame_t act);
		if (act !== exp)
			abortRun($sformatf("FAILED at %0d ns: %s expected 0x%07h got 0x%07h",
				$time, name, exp, act));
	endtask

	// galois lfsr with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per frame bit
	task automatic randomFrame(output pldPkg::frame_t f);
		f = '0;
		for (int i = 0; i < pldPkg::FRAME_W; i++)
		begin
			f = {f[pldPkg::FRAME_W-2:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	// one host write cycle on bank 3
	task automatic writeReg(addr_t a, data_t d);
		@(posedge clk);
		#1;
		nGCS[3] = 1'b0;
		addr = a;
		dataIn = d;
		nWE = 1'b0;
		// hold past the 3 cycle register update
		repeat (6) @(posedge clk);
		#1;
		nWE = 1'b1;
		nGCS[3] = 1'b1;
		repeat (3) @(posedge clk);
	endtask

	// dataOut is valid 4 cycles after nOE falls
	task automatic readReg(addr_t a, output data_t d, output logic drive);
		@(posedge clk);
		#1;
		nGCS[3] = 1'b0;
		nOE = 1'b0;
		addr = a;
		repeat (5) @(posedge clk);
		@(negedge clk);
		d = dataOut;
		drive = dataDrive;
		@(posedge clk);
		#1;
		nOE = 1'b1;
		nGCS[3] = 1'b1;
	endtask

	// msb first with 0 on d0 and 1 on d1
	task automatic sendWiegand(pldPkg::frame_t f, int nBits);
		@(posedge clk);
		#1;
		for (int i = 0; i < nBits; i++)
		begin
			if (f[pldPkg::FRAME_W-1-i])
				wil.d1 = 1'b0;
			else
				wil.d0 = 1'b0;
			repeat (pldPkg::PULSE_CYC) @(posedge clk);
			#1;
			wil = '1;
			repeat (pldPkg::GAP_CYC) @(posedge clk);
			#1;
		end
	endtask

	task automatic addStep(op_e op, addr_t a, data_t d, int idx);
		step_t s;
		s.op = op;
		s.addr = a;
		s.data = d;
		s.idx = idx;
		steps.push_back(s);
	endtask

	task automatic buildTable();
		// reset state
		addStep(OP_CHECK_IRQ, '0, 8'd1, 0);
		addStep(OP_IDLE, '0, '0, 0);
		addStep(OP_GPIO, '0, 8'h00, 0);
		addStep(OP_READ, pldPkg::CFG, 8'h00, 0);
		// gpio and an unmapped address
		addStep(OP_WRITE, pldPkg::GPIO, 8'h0A, 0);
		addStep(OP_GPIO, '0, 8'h0A, 0);
		addStep(OP_READ, pldPkg::GPIO, 8'h0A, 0);
		addStep(OP_READ, addr_t'(20), 8'h00, 0);
		// on done each channel drops its enable and sets its pending bit
		for (int ch = 0; ch < pldPkg::NUM_TX; ch++)
		begin
			addStep(OP_WRFRAME, '0, '0, ch);
			addStep(OP_WRITE, pldPkg::CFG, data_t'(1 << ch), 0);
			addStep(OP_TXEXP, '0, '0, ch);
			addStep(OP_READ, pldPkg::CFG, data_t'(8'h08 << ch), 0);
			addStep(OP_CHECK_IRQ, '0, 8'd0, 0);
			addStep(OP_WRITE, pldPkg::CFG, 8'h00, 0);
			addStep(OP_CHECK_IRQ, '0, 8'd1, 0);
		end
		// full rx frame
		addStep(OP_SEND, '0, data_t'(pldPkg::FRAME_W), 0);
		addStep(OP_WAIT_IRQ, '0, '0, 0);
		addStep(OP_READ, pldPkg::CFG, 8'h80, 0);
		addStep(OP_RDFRAME, '0, '0, 0);
		addStep(OP_WRITE, pldPkg::CFG, 8'h00, 0);
		addStep(OP_CHECK_IRQ, '0, 8'd1, 0);
		// short burst leaves the readback at slot 0
		addStep(OP_SEND, '0, 8'd20, 1);
		addStep(OP_READ, pldPkg::CFG, 8'h00, 0);
		addStep(OP_RDFRAME, '0, '0, 0);
		addStep(OP_CHECK_IRQ, '0, 8'd1, 0);
		// lock held low
		addStep(OP_LOCK, '0, 8'd0, 0);
		addStep(OP_WAIT_IRQ, '0, '0, 0);
		addStep(OP_READ, pldPkg::CFG, 8'h40, 0);
		addStep(OP_LOCK, '0, 8'd1, 0);
		addStep(OP_WRITE, pldPkg::CFG, 8'h00, 0);
		addStep(OP_CHECK_IRQ, '0, 8'd1, 0);
	endtask

	// rough cycle cost of one step
	function automatic int stepCycles(step_t s);
		case (s.op)
			OP_WRITE: return 10;
			OP_READ: return 8;
			OP_WRFRAME: return 10 * pldPkg::FRAME_BYTES;
			OP_RDFRAME: return 8 * pldPkg::FRAME_BYTES;
			OP_TXEXP: return pldPkg::FRAME_W * (pldPkg::PULSE_CYC + pldPkg::GAP_CYC) + 16;
			OP_SEND:
				return int'(s.data) * (pldPkg::PULSE_CYC + pldPkg::GAP_CYC)
					+ pldPkg::RX_IDLE_CYC + 16;
			OP_WAIT_IRQ: return pldPkg::RX_IDLE_CYC + 8;
			default: return 2;
		endcase
	endfunction

	task automatic runStep(step_t st);
		data_t got;
		logic drive;
		wide_t wide;
		case (st.op)
			OP_WRITE:
				writeReg(st.addr, st.data);
			OP_READ:
			begin
				readReg(st.addr, got, drive);
				checkData("dataDrive", data_t'(1'b1), data_t'(drive));
				checkData($sformatf("dataOut at addr %0d", st.addr), st.data, got);
			end
			OP_WRFRAME:
			begin
				// byte k holds frame bits 8k up
				wide = '0;
				wide[pldPkg::FRAME_W-1:0] = txFrames[st.idx];
				for (int k = 0; k < pldPkg::FRAME_BYTES; k++)
					writeReg(addr_t'(int'(pldPkg::FRAME0) + pldPkg::FRAME_BYTES * st.idx + k),
						wide[k*pldPkg::DATA_W +: pldPkg::DATA_W]);
			end
			OP_RDFRAME:
			begin
				for (int k = 0; k < pldPkg::FRAME_BYTES; k++)
				begin
					readReg(addr_t'(int'(pldPkg::FRAME0) + k), got, drive);
					wide[k*pldPkg::DATA_W +: pldPkg::DATA_W] = got;
				end
				checkFrame("rx frame readback", rxFrames[st.idx], wide[pldPkg::FRAME_W-1:0]);
				checkData("rx frame pad bits", '0,
					data_t'(wide[$bits(wide_t)-1:pldPkg::FRAME_W]));
			end
			OP_TXEXP:
			begin
				while (txCount[st.idx] == 0)
					@(negedge clk);
				checkFrame($sformatf("wil_out[%0d] frame", st.idx), txFrames[st.idx],
					monFrame[st.idx]);
			end
			OP_SEND:
			begin
				sendWiegand(rxFrames[st.idx], int'(st.data));
				// a dropped burst ends silently after the idle window
				if (int'(st.data) != pldPkg::FRAME_W)
					repeat (pldPkg::RX_IDLE_CYC + pldPkg::SYNC_STAGES + 8) @(posedge clk);
			end
			OP_WAIT_IRQ:
			begin
				while (eint11 !== 1'b0)
					@(negedge clk);
			end
			OP_CHECK_IRQ:
			begin
				@(negedge clk);
				checkData("eint11", st.data, data_t'(eint11));
			end
			OP_GPIO:
			begin
				@(negedge clk);
				checkData("GPIO", st.data, data_t'(gpioPins));
			end
			OP_IDLE:
			begin
				@(negedge clk);
				for (int ch = 0; ch < pldPkg::NUM_TX; ch++)
					checkData($sformatf("wil_out[%0d]", ch), data_t'(2'b11),
						data_t'(wilOut[ch]));
				// bus idle so the pad buffer stays off
				checkData("dataDrive", '0, data_t'(dataDrive));
			end
			OP_LOCK:
			begin
				@(posedge clk);
				#1;
				lock = st.data[0];
			end
			default:
				abortRun("unknown operation in the stimulus table");
		endcase
	endtask

	// tx pulse decoder that publishes a frame after the last gap
	always @(negedge clk)
	begin
		pldPkg::wiegand_t lineNow;
		if (cfg_rst)
		begin
			for (int ch = 0; ch < pldPkg::NUM_TX; ch++)
			begin
				lineNow = wilOut[ch];
				if (!lineNow.d0 && !lineNow.d1)
					abortRun($sformatf("wil_out[%0d] drove d0 and d1 low together", ch));
				else if (!lineNow.d0 || !lineNow.d1)
				begin
					// first low sample carries the bit
					// d1 low means a 1
					if (lowCnt[ch] == 0)
					begin
						if (monBits[ch] != 0 && highCnt[ch] != pldPkg::GAP_CYC)
							abortRun($sformatf("wil_out[%0d] gap lasted %0d cycles instead of %0d",
								ch, highCnt[ch], pldPkg::GAP_CYC));
						monShift[ch] = {monShift[ch][pldPkg::FRAME_W-2:0], !lineNow.d1};
						monBits[ch]++;
					end
					lowCnt[ch]++;
					highCnt[ch] = 0;
				end
				else if (lowCnt[ch] != 0 && lowCnt[ch] != pldPkg::PULSE_CYC)
					abortRun($sformatf("wil_out[%0d] pulse held low %0d cycles instead of %0d",
						ch, lowCnt[ch], pldPkg::PULSE_CYC));
				else
				begin
					lowCnt[ch] = 0;
					highCnt[ch]++;
					if (monBits[ch] == pldPkg::FRAME_W && highCnt[ch] == pldPkg::GAP_CYC)
					begin
						monFrame[ch] = monShift[ch];
						monBits[ch] = 0;
						txCount[ch]++;
					end
				end
			end
		end
	end

	// limit set once the table is built
	always @(posedge clk)
	begin
		cycles++;
		if (cycleLimit > 0 && cycles > cycleLimit)
			abortRun($sformatf("timeout after %0d cycles, test sequence never completed",
				cycles));
	end

	initial
	begin
		int total;
		cfg_rst = 1'b0;
		nGCS = '1;
		nOE = 1'b1;
		nWE = 1'b1;
		addr = '0;
		dataIn = '0;
		wil = '1;
		lock = 1'b1;
		for (int ch = 0; ch < pldPkg::NUM_TX; ch++)
			randomFrame(txFrames[ch]);
		randomFrame(rxFrames[0]);
		randomFrame(rxFrames[1]);
		buildTable();
		total = 0;
		foreach (steps[i])
			total += stepCycles(steps[i]);
		cycleLimit = 2 * total + 50;
		repeat (3) @(posedge clk);
		#1;
		cfg_rst = 1'b1;
		foreach (steps[i])
			runStep(steps[i]);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== verilog/hostBus.sv ====
module hostBus (
	input logic clk,
	input logic cfg_rst,
	input logic chipSel,
	input logic nOE,
	input logic nWE,
	input logic [pldPkg::ADDR_W-1:0] addr,
	input logic [pldPkg::DATA_W-1:0] dataIn,
	output pldPkg::busWrite_t busWrite,
	output pldPkg::regAddr_e readAddr,
	output logic readEn
);

	// synchronizer chains, last stage is the clean copy
	logic [pldPkg::SYNC_STAGES-1:0] csSync;
	logic [pldPkg::SYNC_STAGES-1:0] oeSync;
	logic [pldPkg::SYNC_STAGES-1:0] weSync;
	logic [pldPkg::SYNC_STAGES-1:0][pldPkg::ADDR_W-1:0] addrSync;
	// previous synced write enable, for edge detect
	logic weLast;
	logic weFall;

	always_ff @(posedge clk)
	begin
		if (!cfg_rst)
		begin
			// strobes start out inactive
			csSync <= '0;
			oeSync <= '1;
			weSync <= '1;
			weLast <= 1'b1;
		end
		else
		begin
			csSync <= {csSync[pldPkg::SYNC_STAGES-2:0], chipSel};
			oeSync <= {oeSync[pldPkg::SYNC_STAGES-2:0], nOE};
			weSync <= {weSync[pldPkg::SYNC_STAGES-2:0], nWE};
			weLast <= weSync[pldPkg::SYNC_STAGES-1];
		end
	end

	// address only feeds the read mux
	always_ff @(posedge clk)
	begin
		addrSync <= {addrSync[pldPkg::SYNC_STAGES-2:0], addr};
	end

	// first cycle of nWE low inside the chip select window
	assign weFall = csSync[pldPkg::SYNC_STAGES-1] && !weSync[pldPkg::SYNC_STAGES-1] && weLast;

	always_ff @(posedge clk)
	begin
		if (!cfg_rst)
			busWrite.valid <= 1'b0;
		else
			busWrite.valid <= weFall;
		// host holds addr and data stable across the write cycle
		if (weFall)
		begin
			busWrite.addr <= pldPkg::regAddr_e'(addr);
			busWrite.data <= dataIn;
		end
	end

	// read side, reloaded every cycle while selected
	assign readEn = csSync[pldPkg::SYNC_STAGES-1] && !oeSync[pldPkg::SYNC_STAGES-1];
	assign readAddr = pldPkg::regAddr_e'(addrSync[pldPkg::SYNC_STAGES-1]);

endmodule

// ==== verilog/pld.sv ====
module pld (
	input logic clk,
	input logic cfg_rst,
	input logic [5:0] nGCS,
	input logic nOE,
	input logic nWE,
	input logic [pldPkg::ADDR_W-1:0] addr,
	input logic [pldPkg::DATA_W-1:0] dataIn,
	input pldPkg::wiegand_t wil,
	input logic lock,
	output logic [pldPkg::DATA_W-1:0] dataOut,
	output logic dataDrive,
	output logic eint11,
	output pldPkg::wiegand_t [pldPkg::NUM_TX-1:0] wil_out,
	output logic [pldPkg::GPIO_W-1:0] GPIO
);

	pldPkg::busWrite_t busWrite;
	pldPkg::regAddr_e readAddr;
	logic readEn;
	logic [pldPkg::NUM_TX-1:0] txStart;
	logic [pldPkg::NUM_TX-1:0] txDone;
	pldPkg::frame_t [pldPkg::NUM_TX-1:0] txFrame;
	pldPkg::frame_t rxFrame;
	logic rxDone;

	// pad buffer enable straight from the raw pins
	assign dataDrive = !nGCS[3] && !nOE;

	// bank 3 holds the register window
	hostBus busInst (
		.clk(clk),
		.cfg_rst(cfg_rst),
		.chipSel(!nGCS[3]),
		.nOE(nOE),
		.nWE(nWE),
		.addr(addr),
		.dataIn(dataIn),
		.busWrite(busWrite),
		.readAddr(readAddr),
		.readEn(readEn)
	);

	regFile regInst (
		.clk(clk),
		.cfg_rst(cfg_rst),
		.busWrite(busWrite),
		.readAddr(readAddr),
		.readEn(readEn),
		.txDone(txDone),
		.rxDone(rxDone),
		.rxFrame(rxFrame),
		.lock(lock),
		.txStart(txStart),
		.txFrame(txFrame),
		.gpio(GPIO),
		.readData(dataOut),
		.eint11(eint11)
	);

	// one serializer per output port
	for (genvar ch = 0; ch < pldPkg::NUM_TX; ch++)
	begin : genTx
		wiegandTx txInst (
			.clk(clk),
			.cfg_rst(cfg_rst),
			.start(txStart[ch]),
			.frame(txFrame[ch]),
			.wiegand(wil_out[ch]),
			.done(txDone[ch])
		);
	end

	wiegandRx rxInst (
		.clk(clk),
		.cfg_rst(cfg_rst),
		.wiegand(wil),
		.frame(rxFrame),
		.done(rxDone)
	);

endmodule

// ==== verilog/pldPkg.sv ====
package pldPkg;

	// host bus widths
	localparam int DATA_W = 8;
	// word address, taken from addr[8:2]
	localparam int ADDR_W = 7;

	// wiegand frame geometry
	localparam int FRAME_W = 26;
	localparam int FRAME_BYTES = (FRAME_W + DATA_W - 1) / DATA_W;
	localparam int NUM_TX = 3;
	localparam int GPIO_W = 4;

	// pulse timing in clk cycles
	localparam int PULSE_CYC = 4;
	localparam int GAP_CYC = 12;
	// quiet time that closes a received frame
	localparam int RX_IDLE_CYC = 40;

	// flops in every input synchronizer
	localparam int SYNC_STAGES = 2;

	// counter widths, sized for the longest count
	localparam int CYC_W = $clog2(RX_IDLE_CYC + 1);
	localparam int BIT_W = $clog2(FRAME_W + 1);

	// configure register layout
	localparam int TX_PEND_LSB = 3;
	localparam int LOCK_BIT = 6;
	localparam int RX_BIT = 7;

	// register map, frame0..3 are tx channel 0 on write and rx frame on read
	typedef enum logic [ADDR_W-1:0] {
		CFG = 7'd0,
		FRAME0 = 7'd1,
		FRAME1 = 7'd2,
		FRAME2 = 7'd3,
		FRAME3 = 7'd4,
		CH1_FRAME0 = 7'd5,
		CH1_FRAME1 = 7'd6,
		CH1_FRAME2 = 7'd7,
		CH1_FRAME3 = 7'd8,
		CH2_FRAME0 = 7'd9,
		CH2_FRAME1 = 7'd10,
		CH2_FRAME2 = 7'd11,
		CH2_FRAME3 = 7'd12,
		GPIO = 7'd13
	} regAddr_e;

	typedef logic [FRAME_W-1:0] frame_t;
	typedef logic [CYC_W-1:0] cycCnt_t;
	typedef logic [BIT_W-1:0] bitCnt_t;

	// one-cycle write strobe from the bus front end
	typedef struct packed {
		logic valid;
		regAddr_e addr;
		logic [DATA_W-1:0] data;
	} busWrite_t;

	// both lines idle high
	typedef struct packed {
		logic d1;
		logic d0;
	} wiegand_t;

	typedef enum logic [1:0] {TX_IDLE, TX_PULSE, TX_GAP} txState_e;
	typedef enum logic {RX_IDLE, RX_RECV} rxState_e;

endpackage

// ==== verilog/regFile.sv ====
module regFile (
	input logic clk,
	input logic cfg_rst,
	input pldPkg::busWrite_t busWrite,
	input pldPkg::regAddr_e readAddr,
	input logic readEn,
	input logic [pldPkg::NUM_TX-1:0] txDone,
	input logic rxDone,
	input pldPkg::frame_t rxFrame,
	input logic lock,
	output logic [pldPkg::NUM_TX-1:0] txStart,
	output pldPkg::frame_t [pldPkg::NUM_TX-1:0] txFrame,
	output logic [pldPkg::GPIO_W-1:0] gpio,
	output logic [pldPkg::DATA_W-1:0] readData,
	output logic eint11
);

	// configure: enables [2:0], tx pending [5:3], lock pending 6, rx pending 7
	logic [pldPkg::DATA_W-1:0] cfgReg;
	logic [pldPkg::DATA_W-1:0] cfgNext;
	pldPkg::frame_t rxLatch;
	logic [pldPkg::SYNC_STAGES-1:0] lockSync;
	logic cfgWr;
	logic gpioWr;
	logic [pldPkg::NUM_TX-1:0] frameWr;
	int frameByte;
	logic [pldPkg::DATA_W-1:0] readNext;
	logic [pldPkg::FRAME_BYTES*pldPkg::DATA_W-1:0] rxWide;

	// replace one byte of a frame, top byte is only partly used
	function automatic pldPkg::frame_t putByte(
		pldPkg::frame_t cur,
		int idx,
		logic [pldPkg::DATA_W-1:0] val
	);
		logic [pldPkg::FRAME_BYTES*pldPkg::DATA_W-1:0] wide;
		wide = '0;
		wide[pldPkg::FRAME_W-1:0] = cur;
		wide[idx*pldPkg::DATA_W +: pldPkg::DATA_W] = val;
		return wide[pldPkg::FRAME_W-1:0];
	endfunction

	assign cfgWr = busWrite.valid && (busWrite.addr == pldPkg::CFG);
	assign gpioWr = busWrite.valid && (busWrite.addr == pldPkg::GPIO);

	// frame bytes 1..12, four per channel
	always_comb
	begin
		int frameOff;
		logic inRange;
		frameOff = int'(busWrite.addr) - int'(pldPkg::FRAME0);
		inRange = busWrite.valid && (busWrite.addr >= pldPkg::FRAME0)
			&& (busWrite.addr <= pldPkg::CH2_FRAME3);
		frameByte = frameOff % pldPkg::FRAME_BYTES;
		for (int ch = 0; ch < pldPkg::NUM_TX; ch++)
			frameWr[ch] = inRange && (frameOff / pldPkg::FRAME_BYTES == ch);
	end

	// host write first, hardware events override it
	always_comb
	begin
		cfgNext = cfgReg;
		if (cfgWr)
			cfgNext = busWrite.data;
		for (int ch = 0; ch < pldPkg::NUM_TX; ch++)
		begin
			if (txDone[ch])
			begin
				// frame sent, drop enable and flag it
				cfgNext[ch] = 1'b0;
				cfgNext[pldPkg::TX_PEND_LSB + ch] = 1'b1;
			end
		end
		// level sensitive, stays set while lock is held low
		if (!lockSync[pldPkg::SYNC_STAGES-1])
			cfgNext[pldPkg::LOCK_BIT] = 1'b1;
		if (rxDone)
			cfgNext[pldPkg::RX_BIT] = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!cfg_rst)
		begin
			cfgReg <= '0;
			txStart <= '0;
			lockSync <= '1;
			eint11 <= 1'b1;
		end
		else
		begin
			cfgReg <= cfgNext;
			// start only on a 0 to 1 write of an enable bit
			for (int ch = 0; ch < pldPkg::NUM_TX; ch++)
				txStart[ch] <= cfgWr && busWrite.data[ch] && !cfgReg[ch];
			lockSync <= {lockSync[pldPkg::SYNC_STAGES-2:0], lock};
			// any pending bit pulls the interrupt low
			eint11 <= !(|cfgReg[pldPkg::DATA_W-1:pldPkg::TX_PEND_LSB]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!cfg_rst)
		begin
			txFrame <= '0;
			gpio <= '0;
			rxLatch <= '0;
		end
		else
		begin
			for (int ch = 0; ch < pldPkg::NUM_TX; ch++)
				if (frameWr[ch])
					txFrame[ch] <= putByte(txFrame[ch], frameByte, busWrite.data);
			if (gpioWr)
				gpio <= busWrite.data[pldPkg::GPIO_W-1:0];
			if (rxDone)
				rxLatch <= rxFrame;
		end
	end

	// readback mux
	always_comb
	begin
		rxWide = '0;
		rxWide[pldPkg::FRAME_W-1:0] = rxLatch;
		case (readAddr)
			pldPkg::CFG:
				readNext = cfgReg;
			pldPkg::FRAME0, pldPkg::FRAME1, pldPkg::FRAME2, pldPkg::FRAME3:
				readNext = rxWide[(int'(readAddr) - int'(pldPkg::FRAME0)) * pldPkg::DATA_W
					+: pldPkg::DATA_W];
			pldPkg::GPIO:
				readNext = {{(pldPkg::DATA_W - pldPkg::GPIO_W){1'b0}}, gpio};
			// tx frames are write only, rest unmapped
			default:
				readNext = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!cfg_rst)
			readData <= '0;
		else if (readEn)
			readData <= readNext;
	end

endmodule

// ==== verilog/wiegandRx.sv ====
module wiegandRx (
	input logic clk,
	input logic cfg_rst,
	input pldPkg::wiegand_t wiegand,
	output pldPkg::frame_t frame,
	output logic done
);

	logic [pldPkg::SYNC_STAGES-1:0] d0Sync;
	logic [pldPkg::SYNC_STAGES-1:0] d1Sync;
	// synced lines from the previous cycle
	pldPkg::wiegand_t lineLast;
	logic fall0;
	logic fall1;
	logic anyFall;
	pldPkg::rxState_e state;
	pldPkg::bitCnt_t bitCnt;
	pldPkg::cycCnt_t idleCnt;
	pldPkg::frame_t shiftReg;

	always_ff @(posedge clk)
	begin
		if (!cfg_rst)
		begin
			// lines idle high
			d0Sync <= '1;
			d1Sync <= '1;
			lineLast <= '1;
		end
		else
		begin
			d0Sync <= {d0Sync[pldPkg::SYNC_STAGES-2:0], wiegand.d0};
			d1Sync <= {d1Sync[pldPkg::SYNC_STAGES-2:0], wiegand.d1};
			lineLast.d0 <= d0Sync[pldPkg::SYNC_STAGES-1];
			lineLast.d1 <= d1Sync[pldPkg::SYNC_STAGES-1];
		end
	end

	// falling edge on either line marks one bit
	assign fall0 = lineLast.d0 && !d0Sync[pldPkg::SYNC_STAGES-1];
	assign fall1 = lineLast.d1 && !d1Sync[pldPkg::SYNC_STAGES-1];
	assign anyFall = fall0 || fall1;

	// d1 wins if both fall together
	always_ff @(posedge clk)
	begin
		if (anyFall)
			shiftReg <= {shiftReg[pldPkg::FRAME_W-2:0], fall1};
	end

	// first bit in ends up as bit 25
	assign frame = shiftReg;

	always_ff @(posedge clk)
	begin
		if (!cfg_rst)
		begin
			state <= pldPkg::RX_IDLE;
			bitCnt <= '0;
			idleCnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				pldPkg::RX_IDLE:
				begin
					if (anyFall)
					begin
						bitCnt <= pldPkg::bitCnt_t'(1);
						idleCnt <= '0;
						state <= pldPkg::RX_RECV;
					end
				end
				pldPkg::RX_RECV:
				begin
					if (anyFall)
					begin
						// saturate so long bursts never wrap back to 26
						if (bitCnt != '1)
							bitCnt <= bitCnt + 1'b1;
						idleCnt <= '0;
					end
					else if (idleCnt == pldPkg::cycCnt_t'(pldPkg::RX_IDLE_CYC - 1))
					begin
						// quiet long enough, keep only full frames
						done <= (bitCnt == pldPkg::bitCnt_t'(pldPkg::FRAME_W));
						state <= pldPkg::RX_IDLE;
					end
					else
						idleCnt <= idleCnt + 1'b1;
				end
				default:
					state <= pldPkg::RX_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/wiegandTx.sv ====
module wiegandTx (
	input logic clk,
	input logic cfg_rst,
	input logic start,
	input pldPkg::frame_t frame,
	output pldPkg::wiegand_t wiegand,
	output logic done
);

	pldPkg::txState_e state;
	// bits still to send after the current one
	pldPkg::bitCnt_t bitCnt;
	// cycles left in the current pulse or gap
	pldPkg::cycCnt_t cycCnt;
	pldPkg::frame_t shiftReg;
	logic nextBit;

	// msb leaves first, next bit sits one below after the shift
	assign nextBit = shiftReg[pldPkg::FRAME_W-2];

	always_ff @(posedge clk)
	begin
		if (!cfg_rst)
		begin
			state <= pldPkg::TX_IDLE;
			bitCnt <= '0;
			cycCnt <= '0;
			wiegand <= '1;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				pldPkg::TX_IDLE:
				begin
					if (start)
					begin
						// 0 pulses d0, 1 pulses d1
						wiegand.d0 <= frame[pldPkg::FRAME_W-1];
						wiegand.d1 <= !frame[pldPkg::FRAME_W-1];
						bitCnt <= pldPkg::bitCnt_t'(pldPkg::FRAME_W - 1);
						cycCnt <= pldPkg::cycCnt_t'(pldPkg::PULSE_CYC - 1);
						state <= pldPkg::TX_PULSE;
					end
				end
				pldPkg::TX_PULSE:
				begin
					if (cycCnt == '0)
					begin
						wiegand <= '1;
						cycCnt <= pldPkg::cycCnt_t'(pldPkg::GAP_CYC - 1);
						state <= pldPkg::TX_GAP;
					end
					else
						cycCnt <= cycCnt - 1'b1;
				end
				pldPkg::TX_GAP:
				begin
					if (cycCnt != '0)
						cycCnt <= cycCnt - 1'b1;
					else if (bitCnt == '0)
					begin
						// last gap over, frame complete
						done <= 1'b1;
						state <= pldPkg::TX_IDLE;
					end
					else
					begin
						wiegand.d0 <= nextBit;
						wiegand.d1 <= !nextBit;
						bitCnt <= bitCnt - 1'b1;
						cycCnt <= pldPkg::cycCnt_t'(pldPkg::PULSE_CYC - 1);
						state <= pldPkg::TX_PULSE;
					end
				end
				default:
					state <= pldPkg::TX_IDLE;
			endcase
		end
		// frame shifter, a start while busy is ignored
		if (state == pldPkg::TX_IDLE && start)
			shiftReg <= frame;
		else if (state == pldPkg::TX_GAP && cycCnt == '0 && bitCnt != '0)
			shiftReg <= shiftReg << 1;
	end

endmodule
